// ==== Makefile ====
# Verilator flow for the MIPS core and its testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_mips
RTL_TOP   ?= mips
FILELIST  ?= mips.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== mips.f ====
+incdir+.
mips_pkg.sv
mips_imem.sv
mips_regfile.sv
mips_controller.sv
mips_datapath.sv
mips_bus_interface.sv
mips.sv
tb_mips.sv

// ==== mips.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module mips
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       reset_ext,
  input  bus_ctrl_t  bus_ctrl_in,
  input  logic       bus_ack,
  input  logic [4:0] debug_ra4,
  output bus_ctrl_t  bus_ctrl_out,
  output logic       bus_req,
  output word_t      debug_rd4,
  input  word_t      bus_data_in,
  output word_t      bus_data_out
);

  localparam int IMEM_AW = $clog2(`MIPS_IMEM_WORDS);

  logic               reset;
  logic               loading;
  instr_u             ir;
  ctrl_t              ctrl;
  logic               stall;
  logic               bubble;
  logic               taken;
  word_t              pc;
  word_t              next_pc;
  word_t              fetch_pc;
  word_t              imem_rdata;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_waddr;
  logic [IMEM_AW-1:0] imem_addr;
  word_t              alu_out;
  word_t              writedata;
  word_t              readdata;
  logic               load_done;

  always_ff @(posedge clk) begin
    reset <= reset_ext;  // One cycle behind the pin
  end

  assign loading = reset_ext;

  // In reset the PC already sits at the reset vector, so fetch from it
  assign fetch_pc  = reset ? pc : next_pc;
  assign imem_addr = loading ? imem_waddr : fetch_pc[IMEM_AW+1:2];

  mips_imem imem (
    .clk   (clk),
    .addr  (imem_addr),
    .we    (imem_we),
    .wdata (bus_data_in),
    .rdata (imem_rdata)
  );

  // Instruction register, frozen during bus cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (!stall) begin
      ir <= imem_rdata;
    end
  end

  // The word after a taken branch or jump is discarded
  always_ff @(posedge clk) begin
    if (reset) begin
      bubble <= 1'b0;
    end else begin
      bubble <= taken;
    end
  end

  mips_controller ctl (
    .instr (ir),
    .ctrl  (ctrl)
  );

  mips_datapath dp (
    .clk       (clk),
    .reset     (reset),
    .instr     (ir),
    .ctrl      (ctrl),
    .stall     (stall),
    .bubble    (bubble),
    .readdata  (readdata),
    .load_done (load_done),
    .pc        (pc),
    .next_pc   (next_pc),
    .taken     (taken),
    .alu_out   (alu_out),
    .writedata (writedata),
    .debug_ra4 (debug_ra4),
    .debug_rd4 (debug_rd4)
  );

  mips_bus_interface bus_if (
    .clk          (clk),
    .reset        (reset),
    .memread      (ctrl.memread & ~bubble),
    .memwrite     (ctrl.memwrite & ~bubble),
    .alu_out      (alu_out),
    .writedata    (writedata),
    .bus_ack      (bus_ack),
    .bus_ctrl_in  (bus_ctrl_in),
    .bus_data_in  (bus_data_in),
    .loading      (loading),
    .bus_req      (bus_req),
    .bus_ctrl_out (bus_ctrl_out),
    .bus_data_out (bus_data_out),
    .readdata     (readdata),
    .load_done    (load_done),
    .stall        (stall),
    .imem_we      (imem_we),
    .imem_waddr   (imem_waddr)
  );

endmodule

`default_nettype wire

// ==== mips_bus_interface.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module mips_bus_interface
  import mips_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 memread,
  input  logic                                 memwrite,
  input  word_t                                alu_out,
  input  word_t                                writedata,
  input  logic                                 bus_ack,
  input  bus_ctrl_t                            bus_ctrl_in,
  input  word_t                                bus_data_in,
  input  logic                                 loading,
  output logic                                 bus_req,
  output bus_ctrl_t                            bus_ctrl_out,
  output word_t                                bus_data_out,
  output word_t                                readdata,
  output logic                                 load_done,
  output logic                                 stall,
  output logic                                 imem_we,
  output logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  imem_waddr
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_ADDR,
    S_DATA,
    S_WB
  } state_e;

  state_e state;
  state_e state_nxt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:  if (memread || memwrite) state_nxt = S_REQ;
      S_REQ:   if (bus_ack) state_nxt = S_ADDR;  // Wait for the grant
      S_ADDR:  state_nxt = S_DATA;
      S_DATA:  state_nxt = memread ? S_WB : S_IDLE;
      S_WB:    state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  // Held from decode up to the last cycle of the access
  assign stall = ((state == S_IDLE) && (memread || memwrite)) ||
                 (state == S_REQ) || (state == S_ADDR) ||
                 ((state == S_DATA) && memread);

  assign bus_req                 = (state == S_REQ);
  assign bus_ctrl_out.addr_phase = (state == S_ADDR);
  assign bus_ctrl_out.write      = memwrite && ((state == S_ADDR) || (state == S_DATA));
  assign load_done               = (state == S_WB);

  always_comb begin
    if (state == S_ADDR) begin
      bus_data_out = alu_out;
    end else if ((state == S_DATA) && memwrite) begin
      bus_data_out = writedata;
    end else begin
      bus_data_out = '0;
    end
  end

  // Read word is sampled at the end of the data phase
  always_ff @(posedge clk) begin
    if (state == S_DATA) begin
      readdata <= bus_data_in;
    end
  end

  // Loader; an address strobe sets the word index, each data strobe bumps it
  assign imem_we = loading && bus_ctrl_in.write && !bus_ctrl_in.addr_phase;

  always_ff @(posedge clk) begin
    if (loading && bus_ctrl_in.write && bus_ctrl_in.addr_phase) begin
      imem_waddr <= bus_data_in[$clog2(`MIPS_IMEM_WORDS)-1:0];
    end else if (imem_we) begin
      imem_waddr <= imem_waddr + 1'b1;
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    bus_req && !bus_ack |=> bus_req);

  // Program loading never overlaps a core bus cycle
  a_load_only: assert property (@(posedge clk)
    imem_we |-> loading && (state == S_IDLE));

endmodule

`default_nettype wire

// ==== mips_controller.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module mips_controller
  import mips_pkg::*;
(
  input  instr_u instr,
  output ctrl_t  ctrl
);

  always_comb begin
    ctrl = '0;  // No-op unless decoded below
    case (instr.i.op)
      `OP_RTYPE: begin
        ctrl.regwrite = 1'b1;
        ctrl.regdst   = 1'b1;
        case (instr.r.funct)
          `FN_ADDU: ctrl.alu_op = ALU_ADD;
          `FN_SUBU: ctrl.alu_op = ALU_SUB;
          `FN_AND:  ctrl.alu_op = ALU_AND;
          `FN_OR:   ctrl.alu_op = ALU_OR;
          `FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: begin
            ctrl.regwrite = 1'b0;  // Unsupported funct, e.g. sll 0 nop
            ctrl.regdst   = 1'b0;
          end
        endcase
      end
      `OP_ADDIU: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
      end
      `OP_LW: begin
        ctrl.regwrite = 1'b1;   // Committed only once the load data is back
        ctrl.alusrc   = 1'b1;
        ctrl.memtoreg = 1'b1;
        ctrl.memread  = 1'b1;
      end
      `OP_SW: begin
        ctrl.alusrc   = 1'b1;
        ctrl.memwrite = 1'b1;
      end
      `OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;  // Zero result means equal
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== mips_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module mips_datapath
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  instr_u     instr,
  input  ctrl_t      ctrl,
  input  logic       stall,
  input  logic       bubble,
  input  word_t      readdata,
  input  logic       load_done,
  output word_t      pc,
  output word_t      next_pc,
  output logic       taken,
  output word_t      alu_out,
  output word_t      writedata,
  input  logic [4:0] debug_ra4,
  output word_t      debug_rd4
);

  word_t      rd1;
  word_t      rd2;
  word_t      signimm;
  word_t      srcb;
  word_t      wd;
  word_t      branch_target;
  word_t      jump_target;
  logic [4:0] wa;
  logic       we;
  logic       zero;

  // The PC is the fetch address, one word past the instruction in execute
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  assign signimm       = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign srcb          = ctrl.alusrc ? signimm : rd2;
  assign branch_target = pc + {signimm[29:0], 2'b00};
  assign jump_target   = {pc[31:28], instr.j.target, 2'b00};

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: alu_out = rd1 + srcb;
      ALU_SUB: alu_out = rd1 - srcb;
      ALU_AND: alu_out = rd1 & srcb;
      ALU_OR:  alu_out = rd1 | srcb;
      ALU_SLT: alu_out = {31'd0, $signed(rd1) < $signed(srcb)};
      default: alu_out = '0;
    endcase
  end

  assign zero      = (alu_out == '0);
  assign writedata = rd2;

  // The bubble cycle carries a wrong-path word, so it must not redirect
  assign taken = ~bubble & (ctrl.jump | (ctrl.branch & zero));

  always_comb begin
    if (stall) begin
      next_pc = pc;  // Refetch the same word while a bus cycle runs
    end else if (taken && ctrl.jump) begin
      next_pc = jump_target;
    end else if (taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // Loads write back only in their final cycle
  assign we = ~bubble & (load_done | (ctrl.regwrite & ~ctrl.memtoreg));
  assign wa = ctrl.regdst ? instr.r.rd : instr.r.rt;
  assign wd = ctrl.memtoreg ? readdata : alu_out;

  mips_regfile rf (
    .clk       (clk),
    .we        (we),
    .ra1       (instr.r.rs),
    .ra2       (instr.r.rt),
    .wa        (wa),
    .wd        (wd),
    .rd1       (rd1),
    .rd2       (rd2),
    .debug_ra4 (debug_ra4),
    .debug_rd4 (debug_rd4)
  );

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== mips_imem.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module mips_imem
  import mips_pkg::*;
(
  input  logic                                 clk,
  input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  addr,
  input  logic                                 we,
  input  word_t                                wdata,
  output word_t                                rdata
);

  word_t mem [0:`MIPS_IMEM_WORDS-1];

  // Single port; the loader shares the address with fetch
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // Registered read
  end

endmodule

`default_nettype wire

// ==== mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Word and memory sizes
`define MIPS_DWIDTH      32
`define MIPS_IMEM_WORDS  256
`define MIPS_RESET_PC    32'h0000_0000

// Primary opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_BEQ    6'h04
`define OP_ADDIU  6'h09
`define OP_LW     6'h23
`define OP_SW     6'h2b

// R-type function codes
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

`endif

// ==== mips_pkg.sv ====
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

  typedef logic [`MIPS_DWIDTH-1:0] word_t;

  // One instruction word, seen through the three encodings
  typedef union packed {
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  op;
      logic [25:0] target;
    } j;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  typedef struct packed {
    logic    regwrite;
    logic    regdst;    // Write rd instead of rt
    logic    alusrc;    // Immediate as ALU operand b
    logic    memtoreg;
    logic    memread;
    logic    memwrite;
    logic    branch;
    logic    jump;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic write;
    logic addr_phase;
  } bus_ctrl_t;

endpackage

`default_nettype wire

// ==== mips_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_regfile
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       we,
  input  logic [4:0] ra1,
  input  logic [4:0] ra2,
  input  logic [4:0] wa,
  input  word_t      wd,
  output word_t      rd1,
  output word_t      rd2,
  input  logic [4:0] debug_ra4,
  output word_t      debug_rd4
);

  word_t regs [0:31];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  // $zero reads back as zero whatever was written to it
  assign rd1       = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2       = (ra2 == 5'd0) ? '0 : regs[ra2];
  assign debug_rd4 = (debug_ra4 == 5'd0) ? '0 : regs[debug_ra4];

  // Decoded rd/rt must be clean whenever a result is committed
  a_wa_known: assert property (@(posedge clk) we |-> !$isunknown(wa));

endmodule

`default_nettype wire

// ==== tb_mips.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_macros.svh"

module tb_mips
  import mips_pkg::*;
();

  localparam int    CLK_PERIOD  = 100;
  localparam int    DRIVE_DELAY = 10;
  localparam int    DMEM_WORDS  = 64;
  localparam int    STEP_LIMIT  = 1000;
  localparam word_t MARKER      = 32'h0000_07d0;  // Last value written to r31

  logic       clk;
  logic       reset_ext;
  bus_ctrl_t  bus_ctrl_in;
  logic       bus_ack;
  logic [4:0] debug_ra4;
  bus_ctrl_t  bus_ctrl_out;
  logic       bus_req;
  word_t      debug_rd4;
  word_t      bus_data_in;
  word_t      bus_data_out;

  word_t  prog [$];
  word_t  init_mem [DMEM_WORDS];
  word_t  bus_mem [DMEM_WORDS];   // Data memory behind the bus
  word_t  ref_regs [32];
  logic   ref_written [32];
  word_t  ref_mem [DMEM_WORDS];
  word_t  acc_addr [$];           // Bus cycles in program order
  logic   acc_write [$];
  word_t  acc_data [$];
  int     acc_idx;
  logic   core_running;
  logic   random_ack;
  int     value_errors;
  int     protocol_errors;
  int     limit_cycles;
  integer seed;

  mips dut0 (
    .clk          (clk),
    .reset_ext    (reset_ext),
    .bus_ctrl_in  (bus_ctrl_in),
    .bus_ack      (bus_ack),
    .debug_ra4    (debug_ra4),
    .bus_ctrl_out (bus_ctrl_out),
    .bus_req      (bus_req),
    .debug_rd4    (debug_rd4),
    .bus_data_in  (bus_data_in),
    .bus_data_out (bus_data_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_store(input int index, input word_t exp_addr, input word_t exp_data,
                             input word_t act_addr, input word_t act_data);
    if ((act_addr !== exp_addr) || (act_data !== exp_data)) begin
      value_errors++;
      $display("Fail at time %0t: bus_data_out store %0d expected %h at %h, actual %h at %h",
               $time, index, exp_data, exp_addr, act_data, act_addr);
    end
  endtask

  task automatic check_ctrl(input string name, input bus_ctrl_t expected,
                            input bus_ctrl_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail at time %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail at time %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  // Instruction encoders in MIPS field order
  function automatic word_t enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                  input logic [4:0] rs, input logic [4:0] rt);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rt,
                                  input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input logic [25:0] target);
    return {`OP_J, target};
  endfunction

  function automatic void build_program();
    prog.delete();
    prog.push_back(enc_i(`OP_ADDIU, 5'd31, 5'd0, 16'h0000));  // Word 0 clears the marker
    prog.push_back(enc_i(`OP_ADDIU, 5'd13, 5'd0, 16'h0011));
    prog.push_back(enc_i(`OP_ADDIU, 5'd17, 5'd0, 16'h0022));
    prog.push_back(enc_i(`OP_ADDIU, 5'd1, 5'd0, 16'h0005));
    prog.push_back(enc_i(`OP_ADDIU, 5'd2, 5'd0, 16'hfffd));   // Minus 3 into r2
    prog.push_back(enc_r(`FN_ADDU, 5'd3, 5'd1, 5'd2));
    prog.push_back(enc_r(`FN_SUBU, 5'd4, 5'd2, 5'd1));
    prog.push_back(enc_r(`FN_AND, 5'd5, 5'd1, 5'd2));
    prog.push_back(enc_r(`FN_OR, 5'd6, 5'd1, 5'd2));
    prog.push_back(enc_r(`FN_SLT, 5'd7, 5'd2, 5'd1));
    prog.push_back(enc_r(`FN_SLT, 5'd8, 5'd1, 5'd2));
    prog.push_back(enc_i(`OP_ADDIU, 5'd9, 5'd0, 16'h0010));   // Data base at word 11
    prog.push_back(enc_i(`OP_LW, 5'd10, 5'd9, 16'h0000));
    prog.push_back(enc_i(`OP_LW, 5'd0, 5'd9, 16'h0004));      // Load into $zero
    prog.push_back(enc_r(`FN_ADDU, 5'd11, 5'd10, 5'd1));
    prog.push_back(enc_i(`OP_SW, 5'd11, 5'd9, 16'h0008));
    prog.push_back(enc_i(`OP_SW, 5'd4, 5'd9, 16'h000c));
    prog.push_back(enc_i(`OP_LW, 5'd12, 5'd9, 16'h0008));     // Word 17 reads back a store
    prog.push_back(enc_i(`OP_BEQ, 5'd11, 5'd12, 16'h0001));   // Taken
    prog.push_back(enc_i(`OP_ADDIU, 5'd13, 5'd0, 16'h0063));
    prog.push_back(enc_i(`OP_BEQ, 5'd2, 5'd1, 16'h0001));     // Word 20 is not taken
    prog.push_back(enc_i(`OP_ADDIU, 5'd14, 5'd0, 16'h0007));
    prog.push_back(enc_i(`OP_ADDIU, 5'd15, 5'd0, 16'h0003));
    prog.push_back(enc_i(`OP_ADDIU, 5'd16, 5'd0, 16'h0000));
    prog.push_back(enc_r(`FN_ADDU, 5'd16, 5'd16, 5'd15));     // Loop body starts at word 24
    prog.push_back(enc_i(`OP_ADDIU, 5'd15, 5'd15, 16'hffff));
    prog.push_back(enc_i(`OP_BEQ, 5'd0, 5'd15, 16'h0001));
    prog.push_back(enc_j(26'd24));
    prog.push_back(enc_i(`OP_SW, 5'd16, 5'd9, 16'h0010));     // Word 28 is also the slot after j
    prog.push_back(enc_j(26'd31));
    prog.push_back(enc_i(`OP_ADDIU, 5'd17, 5'd0, 16'h0001));
    prog.push_back(enc_i(`OP_SW, 5'd0, 5'd9, 16'h0014));
    prog.push_back(enc_i(`OP_ADDIU, 5'd31, 5'd0, MARKER[15:0]));
    prog.push_back(enc_j(26'd33));                            // Word 33 halts in a self-jump
  endfunction

  // Instruction-set model without a delay slot
  function automatic void reference_run();
    word_t      pc;
    word_t      next;
    instr_u     ins;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      ea;
    word_t      wval;
    logic [4:0] dst;
    logic       wen;
    logic       halted;
    int         steps;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r]    = '0;
      ref_written[r] = (r == 0);  // $zero is always checked
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
      ref_mem[w] = init_mem[w];
    end
    acc_addr.delete();
    acc_write.delete();
    acc_data.delete();
    pc     = `MIPS_RESET_PC;
    halted = 1'b0;
    steps  = 0;
    while (!halted && (steps < STEP_LIMIT)) begin
      ins  = prog[pc[31:2]];
      a    = ref_regs[ins.r.rs];
      b    = ref_regs[ins.r.rt];
      imm  = {{16{ins.i.imm[15]}}, ins.i.imm};
      ea   = a + imm;
      next = pc + 32'd4;
      wen  = 1'b0;
      dst  = ins.i.rt;
      wval = '0;
      case (ins.r.op)
        `OP_RTYPE: begin
          wen = 1'b1;
          dst = ins.r.rd;
          case (ins.r.funct)
            `FN_ADDU: wval = a + b;
            `FN_SUBU: wval = a - b;
            `FN_AND:  wval = a & b;
            `FN_OR:   wval = a | b;
            `FN_SLT:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  wen = 1'b0;
          endcase
        end
        `OP_ADDIU: begin
          wen  = 1'b1;
          wval = ea;
        end
        `OP_LW: begin
          wen  = 1'b1;
          wval = ref_mem[ea[7:2]];
          acc_addr.push_back(ea);
          acc_write.push_back(1'b0);
          acc_data.push_back('0);
        end
        `OP_SW: begin
          ref_mem[ea[7:2]] = b;
          acc_addr.push_back(ea);
          acc_write.push_back(1'b1);
          acc_data.push_back(b);
        end
        `OP_BEQ: if (a == b) next = pc + 32'd4 + (imm << 2);
        `OP_J: begin
          next   = {next[31:28], ins.j.target, 2'b00};
          halted = (next == pc);
        end
        default: ;
      endcase
      if (wen && (dst != 5'd0)) begin
        ref_regs[dst]    = wval;
        ref_written[dst] = 1'b1;
      end
      pc = next;
      steps++;
    end
  endfunction

  task automatic load_program();
    bus_ctrl_in = '{write: 1'b1, addr_phase: 1'b1};
    bus_data_in = '0;  // Start address is word 0
    for (int i = 0; i < prog.size(); i++) begin
      next_cycle();
      bus_ctrl_in = '{write: 1'b1, addr_phase: 1'b0};
      bus_data_in = prog[i];
    end
    next_cycle();
    bus_ctrl_in = '0;
  endtask

  task automatic read_reg(input logic [4:0] idx, output word_t val);
    next_cycle();
    debug_ra4 = idx;
    #(CLK_PERIOD / 2 - DRIVE_DELAY);
    val = debug_rd4;  // Sampled mid-cycle
  endtask

  task automatic run_program(input logic use_random);
    word_t val;
    reset_ext = 1'b1;
    repeat (2) next_cycle();
    load_program();
    repeat (2) next_cycle();
    @(negedge clk);
    for (int w = 0; w < DMEM_WORDS; w++) begin
      bus_mem[w] = init_mem[w];
    end
    acc_idx      = 0;
    random_ack   = use_random;
    core_running = 1'b1;
    next_cycle();
    reset_ext = 1'b0;
    // A leftover marker from the previous run must be cleared first
    read_reg(5'd31, val);
    while (val === MARKER) read_reg(5'd31, val);
    while (val !== MARKER) read_reg(5'd31, val);
    for (int r = 0; r < 32; r++) begin
      if (ref_written[r]) begin
        read_reg(r[4:0], val);
        check_word($sformatf("debug_rd4 (r%0d)", r), ref_regs[r], val);
      end
    end
    if (acc_idx != acc_addr.size()) begin
      protocol_errors++;
      $display("Error: the core made %0d bus cycles, the reference predicts %0d",
               acc_idx, acc_addr.size());
    end
    @(negedge clk);
    core_running = 1'b0;
    next_cycle();
  endtask

  // Bus memory model that answers core cycles and compares them in order
  initial begin : bus_agent
    word_t     addr;
    logic      wr;
    int        delay;
    bus_ctrl_t exp_ctrl;
    forever begin
      next_cycle();
      if (core_running && (bus_req !== 1'b1)) begin
        check_bit("bus_req", 1'b0, bus_req);
        check_ctrl("bus_ctrl_out", '0, bus_ctrl_out);  // Idle bus
      end else if (core_running) begin
        delay = random_ack ? ($unsigned($random(seed)) % 6) : 0;
        repeat (delay) begin
          check_ctrl("bus_ctrl_out", '0, bus_ctrl_out);
          next_cycle();
          check_bit("bus_req", 1'b1, bus_req);  // Held until acknowledged
        end
        bus_ack = 1'b1;
        next_cycle();
        bus_ack = 1'b0;
        exp_ctrl.write      = (acc_idx < acc_addr.size()) ? acc_write[acc_idx] : 1'b0;
        exp_ctrl.addr_phase = 1'b1;
        check_bit("bus_req", 1'b0, bus_req);
        check_ctrl("bus_ctrl_out", exp_ctrl, bus_ctrl_out);
        addr = bus_data_out;
        wr   = bus_ctrl_out.write;
        next_cycle();
        exp_ctrl.addr_phase = 1'b0;
        check_ctrl("bus_ctrl_out", exp_ctrl, bus_ctrl_out);
        if (acc_idx >= acc_addr.size()) begin
          protocol_errors++;
          $display("Error at time %0t: bus cycle to %h that the reference does not predict",
                   $time, addr);
        end else if (acc_write[acc_idx] !== wr) begin
          protocol_errors++;
          $display("Error at time %0t: bus cycle %0d has the wrong direction", $time, acc_idx);
        end else if (wr) begin
          check_store(acc_idx, acc_addr[acc_idx], acc_data[acc_idx], addr, bus_data_out);
        end else begin
          check_word("bus_data_out (load address)", acc_addr[acc_idx], addr);
        end
        if (wr) begin
          bus_mem[addr[7:2]] = bus_data_out;
        end else begin
          bus_data_in = bus_mem[addr[7:2]];  // Data phase of a load
        end
        acc_idx++;
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: the program did not reach its halt loop within %0d cycles",
             limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    clk             = 1'b0;
    reset_ext       = 1'b1;
    bus_ctrl_in     = '0;
    bus_ack         = 1'b0;
    debug_ra4       = '0;
    bus_data_in     = '0;
    core_running    = 1'b0;
    random_ack      = 1'b0;
    acc_idx         = 0;
    value_errors    = 0;
    protocol_errors = 0;
    seed            = 6228;
    build_program();
    for (int w = 0; w < DMEM_WORDS; w++) begin
      init_mem[w] = $random(seed);
    end
    reference_run();
    // Per run one load cycle and 20 execute cycles per word, plus reset and readback
    limit_cycles = 2 * (prog.size() * 21 + 80);
    next_cycle();
    run_program(1'b0);  // Immediate acknowledge
    run_program(1'b1);  // Random acknowledge delays
    $display("Errors: %0d value mismatches, %0d protocol errors",
             value_errors, protocol_errors);
    if ((value_errors + protocol_errors) == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
